// File: board_store.sv
`timescale 1ns/100ps
`default_nettype none

module board_store import tetris_geom_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       clear,
	input  logic       lock,
	input  piece_pos_t piece,
	input  logic       load,
	input  board_t     compacted,
	output board_t     board,
	output logic       top_busy
);

	shape_u shape;
	board_t merge;

	assign shape = shape_of(piece.id);

	// Piece cells placed on an empty board
	always_comb begin
		int dy;
		int dx;
		int cx;
		int cy;
		merge = '0;
		for (dy = 0; dy < 4; dy++) begin
			for (dx = 0; dx < 4; dx++) begin
				cx = int'(piece.x) + dx;
				cy = int'(piece.y) + dy;
				if (shape.flat[(3-dy)*4 + (3-dx)] && cx < BOARD_W && cy < BOARD_H) begin
					merge[cy][BOARD_W-1-cx] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			board <= '0;
		end else if (clear) begin
			board <= '0;
		end else if (lock) begin
			board <= board | merge;
		end else if (load) begin
			board <= compacted;
		end
	end

	assign top_busy = |board[0];

endmodule

`default_nettype wire

// File: compile.f
tetris_geom_pkg.sv
tetris_ctrl_pkg.sv
move_checker.sv
line_clearer.sv
board_store.sv
score_counter.sv
game_fsm.sv
tetris_core.sv
tb_clock_gen.sv
tetris_core_assertions.sv
tetris_core_tb.sv

// File: game_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module game_fsm import tetris_geom_pkg::*, tetris_ctrl_pkg::*; #(
	parameter int FALL_TICKS = 40
) (
	input  logic         clk,
	input  logic         reset_n,
	input  move_cmd_t    cmd,
	input  logic         pause,
	input  piece_t       next_piece,
	input  move_ok_t     ok,
	input  logic         top_busy,
	output piece_pos_t   piece,
	output game_status_e status,
	output logic         board_clear,
	output logic         board_lock,
	output logic         board_load,
	output logic         score_clear,
	output logic         score_add
);

	localparam int CNT_W = (FALL_TICKS > 1) ? $clog2(FALL_TICKS) : 1;

	logic [CNT_W-1:0] fall_cnt;
	logic             tick;
	logic             any_cmd;
	piece_pos_t       spawn;

	assign any_cmd = cmd.down | cmd.left | cmd.right | cmd.rotate;
	// Every FALL_TICKS-th PLAY cycle
	assign tick = (fall_cnt == CNT_W'(FALL_TICKS - 1));
	assign spawn = '{id: next_piece, x: col_t'(SPAWN_X), y: row_idx_t'(0)};

	// ==========================================================================
	// Game sequencing
	// ==========================================================================
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			status <= ST_IDLE;
			piece <= '{id: '{kind: PIECE_NONE, rot: rot_t'(0)}, x: col_t'(SPAWN_X),
				y: row_idx_t'(0)};
			fall_cnt <= '0;
		end else begin
			case (status)
				ST_IDLE: begin
					if (any_cmd)
						status <= ST_START;
				end
				ST_START: begin
					piece <= spawn;
					fall_cnt <= '0;
					status <= ST_PLAY;
				end
				ST_PLAY: begin
					if (pause) begin
						status <= ST_PAUSE;
					end else begin
						fall_cnt <= tick ? '0 : fall_cnt + 1'b1;
						if (tick) begin
							if (ok.down)
								piece.y <= piece.y + 5'd1;
							else
								status <= ST_LOCK;
						end else if (cmd.down) begin
							if (ok.down)
								piece.y <= piece.y + 5'd1;
						end else if (cmd.right) begin
							if (ok.right)
								piece.x <= piece.x + 4'd1;
						end else if (cmd.left) begin
							if (ok.left)
								piece.x <= piece.x - 4'd1;
						end else if (cmd.rotate) begin
							if (ok.rotate)
								piece.id.rot <= piece.id.rot + 2'd1;
						end
					end
				end
				ST_PAUSE: begin
					if (!pause)
						status <= ST_PLAY;
				end
				ST_LOCK: begin
					status <= ST_CLEAR;
				end
				ST_CLEAR: begin
					// Board here already holds the merged piece
					if (top_busy) begin
						status <= ST_OVER;
					end else begin
						piece <= spawn;
						status <= ST_PLAY;
					end
				end
				ST_OVER: begin
					if (any_cmd)
						status <= ST_IDLE;
				end
				default: status <= ST_IDLE;
			endcase
		end
	end

	assign board_clear = (status == ST_START);
	assign score_clear = (status == ST_START);
	assign board_lock  = (status == ST_LOCK);
	assign board_load  = (status == ST_CLEAR) && !top_busy;
	assign score_add   = board_load;

endmodule

`default_nettype wire

// File: line_clearer.sv
`timescale 1ns/100ps
`default_nettype none

module line_clearer import tetris_geom_pkg::*, tetris_ctrl_pkg::*; (
	input  board_t      board,
	output board_t      compacted,
	output line_count_t lines
);

	logic [BOARD_H-1:0] full;

	always_comb begin
		int r;
		for (r = 0; r < BOARD_H; r++) begin
			full[r] = &board[r];
		end
	end

	// ==========================================================================
	// Walk up from the bottom, packing kept rows downward
	// ==========================================================================
	always_comb begin
		int r;
		int dst;
		int n;
		compacted = '0;
		dst = BOARD_H - 1;
		n = 0;
		for (r = BOARD_H - 1; r >= 0; r--) begin
			if (full[r]) begin
				n++;
			end else begin
				compacted[dst] = board[r];
				dst--;
			end
		end
		// At most four rows can fill from one piece
		lines = line_count_t'(n);
	end

endmodule

`default_nettype wire

// File: move_checker.sv
`timescale 1ns/100ps
`default_nettype none

module move_checker import tetris_geom_pkg::*, tetris_ctrl_pkg::*; (
	input  board_t     board,
	input  piece_pos_t piece,
	output move_ok_t   ok
);

	// Every set cell inside the board and on an empty cell
	function automatic logic fits(board_t b, piece_t p, int x, int y);
		shape_u s;
		int     dy;
		int     dx;
		int     cx;
		int     cy;
		logic   legal;
		s = shape_of(p);
		legal = 1'b1;
		for (dy = 0; dy < 4; dy++) begin
			for (dx = 0; dx < 4; dx++) begin
				if (s.rows[dy][3-dx]) begin
					cx = x + dx;
					cy = y + dy;
					if (cx < 0 || cx >= BOARD_W || cy < 0 || cy >= BOARD_H) begin
						legal = 1'b0;
					end else if (b[cy][BOARD_W-1-cx]) begin
						legal = 1'b0;
					end
				end
			end
		end
		return legal;
	endfunction

	int     px;
	int     py;
	piece_t rotated;

	assign px = int'(piece.x);
	assign py = int'(piece.y);

	always_comb begin
		rotated = piece.id;
		rotated.rot = piece.id.rot + 2'd1;
	end

	// Candidate placements, one cell away or one rotation on
	assign ok.down   = fits(board, piece.id, px, py + 1);
	assign ok.left   = fits(board, piece.id, px - 1, py);
	assign ok.right  = fits(board, piece.id, px + 1, py);
	assign ok.rotate = fits(board, rotated, px, py);

endmodule

`default_nettype wire

// File: score_counter.sv
`timescale 1ns/100ps
`default_nettype none

module score_counter import tetris_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        clear,
	input  logic        add,
	input  line_count_t lines,
	output score_t      score
);

	bcd_t       points;
	logic [4:0] sum_ones;
	logic       carry_ones;
	logic       carry_tens;
	score_t     next_score;

	always_comb begin
		case (lines)
			3'd1:    points = 4'd1;
			3'd2:    points = 4'd3;
			3'd3:    points = 4'd5;
			3'd4:    points = 4'd8;
			default: points = 4'd0;
		endcase
	end

	// Decimal carry through three digits, wraps past 999
	always_comb begin
		sum_ones = {1'b0, score.ones} + {1'b0, points};
		carry_ones = (sum_ones > 5'd9);
		next_score.ones = carry_ones ? bcd_t'(sum_ones - 5'd10) : bcd_t'(sum_ones);
		carry_tens = carry_ones && (score.tens == 4'd9);
		next_score.tens = carry_tens ? 4'd0 : score.tens + bcd_t'(carry_ones);
		if (carry_tens && score.hundreds == 4'd9) begin
			next_score.hundreds = 4'd0;
		end else begin
			next_score.hundreds = score.hundreds + bcd_t'(carry_tens);
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			score <= '0;
		end else if (clear) begin
			score <= '0;
		end else if (add) begin
			score <= next_score;
		end
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	// Free running, first rising edge half a period in
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2.0);
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: tetris_cases.txt
// Word: op (1 hex digit), arg (2), value (5). Ops: 1 pulse arg times, value down 8 left 4 right 2 rotate 1;
// 2 next piece {kind,rot}; 3 pause; 4 wait for status arg within value cycles;
// 5 expect field arg (0 x, 1 y, 2 kind, 3 rot, 4 score, 5 status) = value; 6 expect board row arg = value
50500000  // IDLE after reset
50200007  // kind NONE
50400000  // score 000
20000001  // next is I, rotation 1
10100001  // any command leaves IDLE
50500001  // START
40200001  // PLAY one edge later
50000004
50100000
50200000
50300001
10100002  // right
50000005
10500004  // left up to the wall
50000000
10100004  // left into the wall is refused
50000000
10100001  // rotate
50300002
10100001
50300003
40400400  // falls and locks on the floor
40200002  // PLAY two edges after LOCK
613003C0  // cols 0 to 3 of the bottom row
61200000
20000004  // next is O
40400400  // second I lands beside the first
40200002
613003FC
20000000  // next is I, rotation 0, for the stack
10400002  // O to the right wall
50000008
10100002  // refused at the wall
50000008
40400400
40200002
61300003  // full row cleared, O top half shifted down
61200000
50400001  // score 001
30000001  // pause
40300002
10100004  // ignored while paused
50000004
50500003
30000000
40200002
40600800  // vertical I pieces stack up column 4
60000020
61300023
50400001
10100008  // any command after game over
50500000
61300023  // board stays visible

// File: tetris_core.sv
`timescale 1ns/100ps
`default_nettype none

module tetris_core import tetris_geom_pkg::*, tetris_ctrl_pkg::*; #(
	parameter int FALL_TICKS = 40
) (
	input  logic         clk,
	input  logic         reset_n,
	input  move_cmd_t    cmd,
	input  logic         pause,
	input  piece_t       next_piece,
	output board_t       board,
	output piece_pos_t   piece,
	output score_t       score,
	output game_status_e status
);

	move_ok_t    ok;
	logic        top_busy;
	board_t      compacted;
	line_count_t lines;
	logic        board_clear;
	logic        board_lock;
	logic        board_load;
	logic        score_clear;
	logic        score_add;

	game_fsm #(
		.FALL_TICKS (FALL_TICKS)
	) game_fsm_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.cmd         (cmd),
		.pause       (pause),
		.next_piece  (next_piece),
		.ok          (ok),
		.top_busy    (top_busy),
		.piece       (piece),
		.status      (status),
		.board_clear (board_clear),
		.board_lock  (board_lock),
		.board_load  (board_load),
		.score_clear (score_clear),
		.score_add   (score_add)
	);

	// Both checks look at the same stored board
	move_checker move_checker_inst (
		.board (board),
		.piece (piece),
		.ok    (ok)
	);

	line_clearer line_clearer_inst (
		.board     (board),
		.compacted (compacted),
		.lines     (lines)
	);

	board_store board_store_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.clear     (board_clear),
		.lock      (board_lock),
		.piece     (piece),
		.load      (board_load),
		.compacted (compacted),
		.board     (board),
		.top_busy  (top_busy)
	);

	score_counter score_counter_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.clear   (score_clear),
		.add     (score_add),
		.lines   (lines),
		.score   (score)
	);

endmodule

`default_nettype wire

// File: tetris_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tetris_core_assertions import tetris_geom_pkg::*, tetris_ctrl_pkg::*; (
	input logic         clk,
	input logic         reset_n,
	input piece_pos_t   piece,
	input score_t       score,
	input game_status_e status
);

	int unsigned failures = 0;

	// BCD digits stay in 0 to 9
	digits_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		score.hundreds <= 4'd9 && score.tens <= 4'd9 && score.ones <= 4'd9)
	else begin
		failures++;
		$error("score digit above 9, score is %h", score);
	end

	lock_then_clear: assert property (@(posedge clk) disable iff (!reset_n)
		status == ST_LOCK |=> status == ST_CLEAR)
	else begin
		failures++;
		$error("LOCK not followed by CLEAR, status is %0d", status);
	end

	// A live piece during play
	piece_in_play: assert property (@(posedge clk) disable iff (!reset_n)
		status == ST_PLAY |-> piece.id.kind != PIECE_NONE)
	else begin
		failures++;
		$error("no piece while in PLAY");
	end

endmodule

bind tetris_core tetris_core_assertions tetris_core_assertions_inst (
	.clk     (clk),
	.reset_n (reset_n),
	.piece   (piece),
	.score   (score),
	.status  (status)
);

`default_nettype wire

// File: tetris_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tetris_core_tb import tetris_geom_pkg::*, tetris_ctrl_pkg::*; ();

	localparam int FALL_TICKS = 16;
	localparam int CLK_PERIOD = 8;
	localparam int MAX_CASES = 64;

	logic         clk;
	logic         reset_n;
	move_cmd_t    cmd;
	logic         pause;
	piece_t       next_piece;
	board_t       board;
	piece_pos_t   piece;
	score_t       score;
	game_status_e status;

	logic [31:0] cases [MAX_CASES];
	int          n_cases;
	int          current;
	int          idx;
	int          checks;
	int          errors;
	int          afails;
	int          fall_model;
	bit          loaded;

	tb_clock_gen #(
		.PERIOD (CLK_PERIOD)
	) tb_clock_gen_inst (
		.clk (clk)
	);

	tetris_core #(
		.FALL_TICKS (FALL_TICKS)
	) tetris_core_inst (
		.clk        (clk),
		.reset_n    (reset_n),
		.cmd        (cmd),
		.pause      (pause),
		.next_piece (next_piece),
		.board      (board),
		.piece      (piece),
		.score      (score),
		.status     (status)
	);

	// Fall timer as the game rules define it, counts unpaused PLAY cycles
	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			fall_model <= 0;
		end else if (status == ST_START) begin
			fall_model <= 0;
		end else if (status == ST_PLAY && !pause) begin
			fall_model <= (fall_model == FALL_TICKS - 1) ? 0 : fall_model + 1;
		end
	end

	// ==========================================================================
	// Stimulus and checking
	// ==========================================================================
	task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR at %0t: case %0d, %s is %0h, expected %0h",
				$time, current, what, got, want);
		end
	endtask

	task automatic idle_gap();
		int n;
		n = $urandom_range(3);
		repeat (n) @(negedge clk);
	endtask

	task automatic pulse_command(input move_cmd_t c);
		idle_gap();
		// A pulse seen on a gravity tick edge would be dropped
		while (status == ST_PLAY && !pause && fall_model == FALL_TICKS - 2) begin
			@(negedge clk);
		end
		@(posedge clk);
		cmd <= c;
		@(posedge clk);
		cmd <= '0;
		@(negedge clk);
	endtask

	task automatic set_next(input piece_t p);
		idle_gap();
		@(posedge clk);
		next_piece <= p;
		@(negedge clk);
	endtask

	task automatic set_pause(input logic level);
		idle_gap();
		@(posedge clk);
		pause <= level;
		@(negedge clk);
	endtask

	task automatic wait_status(input game_status_e want, input int limit);
		int waited;
		waited = 0;
		while (status !== want && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (status !== want) begin
			errors++;
			$display("Case %0d: status did not become %0d within %0d cycles, it is %0d at %0t",
				current, want, limit, status, $time);
		end
	endtask

	task automatic compare_field(input logic [7:0] field, input logic [19:0] want);
		case (field)
			8'd0: check(piece.x, want, "piece x");
			8'd1: check(piece.y, want, "piece y");
			8'd2: check(piece.id.kind, want, "piece kind");
			8'd3: check(piece.id.rot, want, "piece rotation");
			8'd4: check(score, want, "score");
			8'd5: check(status, want, "status");
			default: begin
				errors++;
				$display("Case %0d names an unknown field %0d", current, field);
			end
		endcase
	endtask

	// Word layout is op, arg, value in 4, 8 and 20 bits
	task automatic run_case(input logic [31:0] word);
		logic [3:0]  op;
		logic [7:0]  arg;
		logic [19:0] value;
		op = word[31:28];
		arg = word[27:20];
		value = word[19:0];
		case (op)
			4'h1: repeat ((arg == 0) ? 1 : arg) pulse_command(move_cmd_t'(value[3:0]));
			4'h2: set_next(piece_t'(value[4:0]));
			4'h3: set_pause(value[0]);
			4'h4: wait_status(game_status_e'(arg[2:0]), int'(value));
			4'h5: compare_field(arg, value);
			4'h6: check(board[arg], value, $sformatf("board row %0d", arg));
			default: begin
				errors++;
				$display("Case %0d holds an unknown operation %0h", current, op);
			end
		endcase
	endtask

	initial begin
		cmd = '0;
		pause = 1'b0;
		next_piece = '{kind: PIECE_NONE, rot: rot_t'(0)};
		reset_n = 1'b0;
		checks = 0;
		errors = 0;
		loaded = 1'b0;
		void'($urandom(32'h16046ef8));
		for (idx = 0; idx < MAX_CASES; idx++) begin
			cases[idx] = '0;
		end
		$readmemh("tetris_cases.txt", cases);
		n_cases = 0;
		while (n_cases < MAX_CASES && cases[n_cases] !== 32'h0) begin
			n_cases++;
		end
		loaded = 1'b1;
		if (n_cases == 0) begin
			errors++;
			$display("No cases were read from tetris_cases.txt");
		end
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		for (current = 0; current < n_cases; current++) begin
			run_case(cases[current]);
		end
		afails = tetris_core_inst.tetris_core_assertions_inst.failures;
		$display("Done with %0d cases: %0d checks, %0d errors, %0d assertion failures",
			n_cases, checks, errors, afails);
		if (errors == 0 && afails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog, scaled by the number of cases
	initial begin
		wait (loaded);
		#((n_cases + 1) * 2000 * CLK_PERIOD);
		$display("Timeout: the cases did not complete at %0t", $time);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tetris_ctrl_pkg.sv
`default_nettype none

package tetris_ctrl_pkg;

	// One-cycle command pulses
	typedef struct packed {
		logic down;
		logic left;
		logic right;
		logic rotate;
	} move_cmd_t;

	// Legality of each move for the current piece
	typedef struct packed {
		logic down;
		logic left;
		logic right;
		logic rotate;
	} move_ok_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_PLAY,
		ST_PAUSE,
		ST_LOCK,
		ST_CLEAR,
		ST_OVER
	} game_status_e;

	typedef logic [3:0] bcd_t;

	typedef struct packed {
		bcd_t hundreds;
		bcd_t tens;
		bcd_t ones;
	} score_t;

	typedef logic [2:0] line_count_t;

endpackage

`default_nettype wire

// File: tetris_geom_pkg.sv
`default_nettype none

package tetris_geom_pkg;

	// ==========================================================================
	// Board geometry
	// ==========================================================================
	localparam int BOARD_W = 10;
	localparam int BOARD_H = 20;
	localparam int SPAWN_X = 4;

	// Column c sits at bit BOARD_W-1-c
	typedef logic [BOARD_W-1:0] row_t;
	// Row 0 is the top of the well
	typedef row_t [0:BOARD_H-1] board_t;

	typedef logic [3:0] col_t;
	typedef logic [4:0] row_idx_t;

	// ==========================================================================
	// Pieces
	// ==========================================================================
	typedef enum logic [2:0] {
		PIECE_I,
		PIECE_O,
		PIECE_T,
		PIECE_Z,
		PIECE_S,
		PIECE_L,
		PIECE_J,
		PIECE_NONE
	} piece_kind_e;

	typedef logic [1:0] rot_t;

	typedef struct packed {
		piece_kind_e kind;
		rot_t        rot;
	} piece_t;

	typedef struct packed {
		piece_t   id;
		col_t     x;
		row_idx_t y;
	} piece_pos_t;

	// Cell (dy, dx) at flat bit (3-dy)*4+(3-dx), rows[0] is the top row
	typedef union packed {
		logic [15:0]      flat;
		logic [0:3][3:0]  rows;
	} shape_u;

	localparam logic [15:0] SHAPES [7][4] = '{
		'{16'b1000100010001000, 16'b1111000000000000, 16'b1000100010001000, 16'b1111000000000000},
		'{16'b1100110000000000, 16'b1100110000000000, 16'b1100110000000000, 16'b1100110000000000},
		'{16'b1110010000000000, 16'b0100110001000000, 16'b0100111000000000, 16'b1000110010000000},
		'{16'b1100011000000000, 16'b0100110010000000, 16'b1100011000000000, 16'b0100110010000000},
		'{16'b0110110000000000, 16'b1000110001000000, 16'b0110110000000000, 16'b1000110001000000},
		'{16'b1000100011000000, 16'b1110100000000000, 16'b1100010001000000, 16'b0010111000000000},
		'{16'b0100010011000000, 16'b1000111000000000, 16'b1100100010000000, 16'b1110001000000000}
	};

	// No piece has no cells
	function automatic shape_u shape_of(piece_t p);
		shape_u s;
		if (p.kind == PIECE_NONE) begin
			s.flat = '0;
		end else begin
			s.flat = SHAPES[p.kind][p.rot];
		end
		return s;
	endfunction

endpackage

`default_nettype wire
